//--- decode_out_reg.sv
// decode output register: merges both decoder results and holds them under back-pressure
module decode_out_reg (
    input  logic                      clk,
    input  logic                      rst,
    fetch_if.dst                      fetch_q,
    input  decode_pkg::decode_resp_t  dec,
    input  decode_pkg::cf_t           cf,
    input  logic                      is_controlflow,
    input  decode_pkg::virt_t         jump_i,
    input  decode_pkg::virt_t         jump_j,
    output logic                      out_valid,
    input  logic                      out_ready,
    output decode_pkg::decode_resp_t  out_resp
);
    import decode_pkg::*;

    decode_resp_t merged;

    always_comb begin
        merged                = dec;
        merged.cf             = cf;
        merged.is_controlflow = is_controlflow;
        merged.jump_i         = jump_i;
        merged.jump_j         = jump_j;
    end

    assign fetch_q.ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (fetch_q.ready) begin
            out_valid <= fetch_q.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_q.valid && fetch_q.ready) begin
            out_resp <= merged;  // held while stalled
        end
    end

endmodule

//--- decode_pkg.sv
// decode package: MIPS32 field types, opcode/funct encodings and the decode response
package decode_pkg;

    typedef logic [31:0] virt_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t RA_REG = 5'd31;  // link register

    // major opcodes kept by the decoder
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'b000000,
        OPC_REGIMM  = 6'b000001,
        OPC_J       = 6'b000010,
        OPC_JAL     = 6'b000011,
        OPC_BEQ     = 6'b000100,
        OPC_BNE     = 6'b000101,
        OPC_BLEZ    = 6'b000110,
        OPC_BGTZ    = 6'b000111,
        OPC_ADDI    = 6'b001000,
        OPC_ADDIU   = 6'b001001,
        OPC_SLTI    = 6'b001010,
        OPC_SLTIU   = 6'b001011,
        OPC_ANDI    = 6'b001100,
        OPC_ORI     = 6'b001101,
        OPC_XORI    = 6'b001110,
        OPC_LUI     = 6'b001111,
        OPC_COP0    = 6'b010000,
        OPC_LB      = 6'b100000,
        OPC_LH      = 6'b100001,
        OPC_LW      = 6'b100011,
        OPC_LBU     = 6'b100100,
        OPC_LHU     = 6'b100101,
        OPC_SB      = 6'b101000,
        OPC_SH      = 6'b101001,
        OPC_SW      = 6'b101011
    } opcode_e;

    // SPECIAL funct field
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,  FN_SRL   = 6'd2,  FN_SRA     = 6'd3,  FN_SLLV  = 6'd4,
        FN_SRLV = 6'd6,  FN_SRAV  = 6'd7,  FN_JR      = 6'd8,  FN_JALR  = 6'd9,
        FN_SYSCALL = 6'd12, FN_BREAK = 6'd13,
        FN_MFHI = 6'd16, FN_MTHI  = 6'd17, FN_MFLO    = 6'd18, FN_MTLO  = 6'd19,
        FN_MULT = 6'd24, FN_MULTU = 6'd25, FN_DIV     = 6'd26, FN_DIVU  = 6'd27,
        FN_ADD  = 6'd32, FN_ADDU  = 6'd33, FN_SUB     = 6'd34, FN_SUBU  = 6'd35,
        FN_AND  = 6'd36, FN_OR    = 6'd37, FN_XOR     = 6'd38, FN_NOR   = 6'd39,
        FN_SLT  = 6'd42, FN_SLTU  = 6'd43
    } funct_e;

    typedef enum logic [7:0] {
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_JALR, OP_SYSCALL, OP_BREAK,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU, OP_LUI,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL,
        OP_MFC0, OP_MTC0, OP_ERET,
        OP_INVALID
    } op_t;

    typedef enum logic [2:0] {
        CF_NONE, CF_BRANCH, CF_RETURN, CF_CALL, CF_JUMP
    } cf_t;

    typedef struct packed {
        inst_t     inst;
        op_t       op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      use_imm;
        logic      imm_signed;
        logic      is_load;
        logic      is_store;
        logic      is_multicyc;     // HI/LO unit
        logic      is_controlflow;
        cf_t       cf;
        virt_t     jump_i;          // pc + 4 + offset
        virt_t     jump_j;          // region jump
    } decode_resp_t;

endpackage

//--- fetch_buffer.sv
// fetch buffer: one-entry pipeline register taking fetched instructions into the decode stage
module fetch_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  decode_pkg::virt_t  in_vaddr,
    input  decode_pkg::inst_t  in_inst,
    fetch_if.src               fetch_q
);
    import decode_pkg::*;

    logic  valid_q;
    virt_t vaddr_q;
    inst_t inst_q;
    logic  accept;

    // empty, or the held word leaves this cycle
    assign in_ready = ~valid_q | fetch_q.ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            vaddr_q <= in_vaddr;
            inst_q  <= in_inst;
        end
    end

    assign fetch_q.valid = valid_q;
    assign fetch_q.vaddr = vaddr_q;
    assign fetch_q.inst  = inst_q;

endmodule

//--- fetch_if.sv
// fetch interface: valid/ready handshake carrying one fetched instruction and its address
interface fetch_if;
    import decode_pkg::*;

    logic  valid;
    logic  ready;
    virt_t vaddr;
    inst_t inst;

    // producer side
    modport src (
        output valid,
        output vaddr,
        output inst,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid,
        input  vaddr,
        input  inst,
        output ready
    );

    // decoders only look at the payload
    modport mon (
        input vaddr,
        input inst
    );

endinterface

//--- flow_decode.sv
// control-flow decoder: classifies branches and jumps and computes both targets
module flow_decode (
    fetch_if.mon               fetch_q,
    output decode_pkg::cf_t    cf,
    output logic               is_controlflow,
    output decode_pkg::virt_t  jump_i,
    output decode_pkg::virt_t  jump_j
);
    import decode_pkg::*;

    inst_t     inst;
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt;
    virt_t     pc_plus4;
    logic      is_jr, is_jalr;
    logic      is_branch, is_return, is_call, is_jump;

    assign inst   = fetch_q.inst;
    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];

    assign is_jr   = (opcode == OPC_SPECIAL) && (funct == FN_JR);
    assign is_jalr = (opcode == OPC_SPECIAL) && (funct == FN_JALR);

    // regimm branches are rt 0000x and 1000x
    assign is_branch = (opcode inside {OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ})
                     || ((opcode == OPC_REGIMM) && (rt[3:1] == 3'b000));
    assign is_return = is_jr && (rs == RA_REG);
    assign is_call   = (opcode == OPC_JAL) || is_jalr
                     || ((opcode == OPC_REGIMM) && (rt[4:1] == 4'b1000));
    assign is_jump   = (opcode == OPC_J) || is_jr;

    assign is_controlflow = is_branch | is_return | is_call | is_jump;

    always_comb begin
        unique casez ({is_branch, is_return, is_call, is_jump})
            4'b1???: cf = CF_BRANCH;
            4'b01??: cf = CF_RETURN;
            4'b001?: cf = CF_CALL;
            4'b0001: cf = CF_JUMP;
            default: cf = CF_NONE;
        endcase
    end

    assign pc_plus4 = fetch_q.vaddr + 32'd4;
    assign jump_i   = pc_plus4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    assign jump_j   = {pc_plus4[31:28], inst[25:0], 2'b00};

endmodule

//--- inst_decode_chk.sv
// handshake checker: concurrent assertions on the decode stage ports, bound to the top level
module inst_decode_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input decode_pkg::decode_resp_t  out_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    // stalled response must not move
    a_resp_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_resp)
    ) else $error("out_resp changed while stalled");

    a_rst_empty: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else $error("out_valid high after a reset cycle");

    a_ready_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(in_ready)
    ) else $error("in_ready unknown");

endmodule

bind inst_decode_top inst_decode_chk chk0 (.*);

//--- inst_decode_top.sv
// instruction decode stage top: fetch buffer, decoders and output register
module inst_decode_top #(
    parameter bit COP0_EN = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  decode_pkg::virt_t         in_vaddr,
    input  decode_pkg::inst_t         in_inst,
    output logic                      out_valid,
    input  logic                      out_ready,
    output decode_pkg::decode_resp_t  out_resp
);
    import decode_pkg::*;

    decode_resp_t dec_resp;
    cf_t          cf;
    logic         is_controlflow;
    virt_t        jump_i;
    virt_t        jump_j;

    fetch_if fetch_q ();

    fetch_buffer u_fetch_buffer (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_vaddr (in_vaddr),
        .in_inst  (in_inst),
        .fetch_q  (fetch_q.src)
    );

    op_decode #(
        .COP0_EN (COP0_EN)
    ) u_op_decode (
        .fetch_q (fetch_q.mon),
        .resp    (dec_resp)
    );

    flow_decode u_flow_decode (
        .fetch_q        (fetch_q.mon),
        .cf             (cf),
        .is_controlflow (is_controlflow),
        .jump_i         (jump_i),
        .jump_j         (jump_j)
    );

    decode_out_reg u_decode_out_reg (
        .clk            (clk),
        .rst            (rst),
        .fetch_q        (fetch_q.dst),
        .dec            (dec_resp),
        .cf             (cf),
        .is_controlflow (is_controlflow),
        .jump_i         (jump_i),
        .jump_j         (jump_j),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_resp       (out_resp)
    );

endmodule

//--- op_decode.sv
// operation decoder: maps opcode and funct to operation, register indices and flags
module op_decode #(
    parameter bit COP0_EN = 1'b1
) (
    fetch_if.mon                      fetch_q,
    output decode_pkg::decode_resp_t  resp
);
    import decode_pkg::*;

    inst_t     inst;
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt, rd;

    assign inst   = fetch_q.inst;
    assign opcode = opcode_e'(inst[31:26]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign funct  = funct_e'(inst[5:0]);

    always_comb begin
        resp                = '0;
        resp.inst           = inst;
        resp.op             = OP_INVALID;
        resp.imm_signed     = 1'b1;
        resp.cf             = CF_NONE;  // filled in by flow_decode

        unique case (opcode)
            OPC_SPECIAL: begin
                resp.rs1 = rs;
                resp.rs2 = rt;
                resp.rd  = rd;
                unique casez (inst[5:0])
                    6'b0110??: resp.is_multicyc = 1'b1;  // mult/div
                    6'b0100?1: resp.is_multicyc = 1'b1;  // mthi/mtlo
                    default:   resp.is_multicyc = 1'b0;
                endcase
                unique case (funct)
                    FN_SLL:     resp.op = OP_SLL;
                    FN_SRL:     resp.op = OP_SRL;
                    FN_SRA:     resp.op = OP_SRA;
                    FN_SLLV:    resp.op = OP_SLLV;
                    FN_SRLV:    resp.op = OP_SRLV;
                    FN_SRAV:    resp.op = OP_SRAV;
                    FN_JR:      resp.op = OP_JALR;  // jr shares the jalr path
                    FN_JALR:    resp.op = OP_JALR;
                    FN_SYSCALL: resp.op = OP_SYSCALL;
                    FN_BREAK:   resp.op = OP_BREAK;
                    FN_MFHI:    resp.op = OP_MFHI;
                    FN_MTHI:    resp.op = OP_MTHI;
                    FN_MFLO:    resp.op = OP_MFLO;
                    FN_MTLO:    resp.op = OP_MTLO;
                    FN_MULT:    resp.op = OP_MULT;
                    FN_MULTU:   resp.op = OP_MULTU;
                    FN_DIV:     resp.op = OP_DIV;
                    FN_DIVU:    resp.op = OP_DIVU;
                    FN_ADD:     resp.op = OP_ADD;
                    FN_ADDU:    resp.op = OP_ADDU;
                    FN_SUB:     resp.op = OP_SUB;
                    FN_SUBU:    resp.op = OP_SUBU;
                    FN_AND:     resp.op = OP_AND;
                    FN_OR:      resp.op = OP_OR;
                    FN_XOR:     resp.op = OP_XOR;
                    FN_NOR:     resp.op = OP_NOR;
                    FN_SLT:     resp.op = OP_SLT;
                    FN_SLTU:    resp.op = OP_SLTU;
                    default:    resp.op = OP_INVALID;
                endcase
            end

            OPC_REGIMM: begin
                resp.rs1     = rs;
                resp.rd      = (rt[4:1] == 4'b1000) ? RA_REG : '0;  // link forms
                resp.use_imm = 1'b1;
                unique case (rt)
                    5'b00000: resp.op = OP_BLTZ;
                    5'b00001: resp.op = OP_BGEZ;
                    5'b10000: resp.op = OP_BLTZAL;
                    5'b10001: resp.op = OP_BGEZAL;
                    default:  resp.op = OP_INVALID;
                endcase
            end

            OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ: begin
                resp.rs1 = rs;
                resp.rs2 = rt;
                unique case (inst[27:26])
                    2'b00: resp.op = OP_BEQ;
                    2'b01: resp.op = OP_BNE;
                    2'b10: resp.op = OP_BLEZ;
                    2'b11: resp.op = OP_BGTZ;
                endcase
            end

            OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
            OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                resp.rs1        = rs;
                resp.rd         = rt;
                resp.use_imm    = 1'b1;
                resp.imm_signed = ~inst[28];  // logic ops zero-extend
                unique case (inst[28:26])
                    3'b000: resp.op = OP_ADD;
                    3'b001: resp.op = OP_ADDU;
                    3'b010: resp.op = OP_SLT;
                    3'b011: resp.op = OP_SLTU;
                    3'b100: resp.op = OP_AND;
                    3'b101: resp.op = OP_OR;
                    3'b110: resp.op = OP_XOR;
                    3'b111: resp.op = OP_LUI;
                endcase
            end

            OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU: begin
                resp.rs1     = rs;
                resp.rd      = rt;
                resp.is_load = 1'b1;
                unique case (opcode)
                    OPC_LB:  resp.op = OP_LB;
                    OPC_LH:  resp.op = OP_LH;
                    OPC_LW:  resp.op = OP_LW;
                    OPC_LBU: resp.op = OP_LBU;
                    default: resp.op = OP_LHU;
                endcase
            end

            OPC_SB, OPC_SH, OPC_SW: begin
                resp.rs1      = rs;
                resp.rs2      = rt;
                resp.is_store = 1'b1;
                unique case (opcode)
                    OPC_SB:  resp.op = OP_SB;
                    OPC_SH:  resp.op = OP_SH;
                    default: resp.op = OP_SW;
                endcase
            end

            OPC_J, OPC_JAL: begin
                resp.rd = (opcode == OPC_JAL) ? RA_REG : '0;
                resp.op = OP_JAL;
            end

            OPC_COP0: begin
                if (COP0_EN) begin
                    unique case (rs)
                        5'b00000: begin
                            resp.op = OP_MFC0;
                            resp.rd = rt;
                        end
                        5'b00100: begin
                            resp.op  = OP_MTC0;
                            resp.rs1 = rt;
                        end
                        5'b10000: begin
                            resp.op = (inst[5:0] == 6'b011000) ? OP_ERET : OP_INVALID;
                        end
                        default: resp.op = OP_INVALID;
                    endcase
                end
            end

            default: resp.op = OP_INVALID;
        endcase
    end

endmodule

//--- tb.f
decode_pkg.sv
fetch_if.sv
fetch_buffer.sv
op_decode.sv
flow_decode.sv
decode_out_reg.sv
inst_decode_top.sv
inst_decode_chk.sv
tb_inst_decode.sv

//--- tb_inst_decode.sv
// testbench for the decode stage: directed and random words checked against a reference model
module tb_inst_decode;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic         in_ready;
    virt_t        in_vaddr;
    inst_t        in_inst;
    logic         out_valid;
    logic         out_ready;
    decode_resp_t out_resp;

    decode_resp_t exp_q[$];
    string        cur_test;
    bit           rand_valid;
    bit           rand_ready;
    int           errors;
    int           checks;
    int           sent;
    int           tests;

    inst_decode_top #(.COP0_EN(1'b1)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected decode, written from the ISA field rules
    function automatic decode_resp_t ref_decode(input virt_t va, input inst_t iw);
        decode_resp_t r;
        logic [5:0]   opc;
        logic [5:0]   fn;
        logic [4:0]   rs;
        logic [4:0]   rt;
        virt_t        pc4;
        int           off;
        opc = iw[31:26];
        fn  = iw[5:0];
        rs  = iw[25:21];
        rt  = iw[20:16];
        pc4 = va + 32'd4;
        off = $signed(iw[15:0]);
        r = '0;
        r.inst = iw;
        r.op = OP_INVALID;
        r.imm_signed = 1'b1;
        r.cf = CF_NONE;
        case (opc)
            6'd0: begin
                r.rs1 = rs;
                r.rs2 = rt;
                r.rd  = iw[15:11];
                r.is_multicyc = fn inside {6'd17, 6'd19, 6'd24, 6'd25, 6'd26, 6'd27};
                case (fn)
                    6'd0:  r.op = OP_SLL;
                    6'd2:  r.op = OP_SRL;
                    6'd3:  r.op = OP_SRA;
                    6'd4:  r.op = OP_SLLV;
                    6'd6:  r.op = OP_SRLV;
                    6'd7:  r.op = OP_SRAV;
                    6'd8:  r.op = OP_JALR;  // jr
                    6'd9:  r.op = OP_JALR;
                    6'd12: r.op = OP_SYSCALL;
                    6'd13: r.op = OP_BREAK;
                    6'd16: r.op = OP_MFHI;
                    6'd17: r.op = OP_MTHI;
                    6'd18: r.op = OP_MFLO;
                    6'd19: r.op = OP_MTLO;
                    6'd24: r.op = OP_MULT;
                    6'd25: r.op = OP_MULTU;
                    6'd26: r.op = OP_DIV;
                    6'd27: r.op = OP_DIVU;
                    6'd32: r.op = OP_ADD;
                    6'd33: r.op = OP_ADDU;
                    6'd34: r.op = OP_SUB;
                    6'd35: r.op = OP_SUBU;
                    6'd36: r.op = OP_AND;
                    6'd37: r.op = OP_OR;
                    6'd38: r.op = OP_XOR;
                    6'd39: r.op = OP_NOR;
                    6'd42: r.op = OP_SLT;
                    6'd43: r.op = OP_SLTU;
                    default: r.op = OP_INVALID;
                endcase
                if (fn == 6'd8)
                    r.cf = (rs == 5'd31) ? CF_RETURN : CF_JUMP;
                if (fn == 6'd9)
                    r.cf = CF_CALL;
            end
            6'd1: begin
                r.rs1 = rs;
                r.use_imm = 1'b1;
                case (rt)
                    5'd0:  r.op = OP_BLTZ;
                    5'd1:  r.op = OP_BGEZ;
                    5'd16: r.op = OP_BLTZAL;
                    5'd17: r.op = OP_BGEZAL;
                    default: r.op = OP_INVALID;
                endcase
                if (rt inside {5'd16, 5'd17})
                    r.rd = 5'd31;
                if (r.op != OP_INVALID)
                    r.cf = CF_BRANCH;  // branch wins over call
            end
            6'd2: begin
                r.op = OP_JAL;
                r.cf = CF_JUMP;
            end
            6'd3: begin
                r.op = OP_JAL;
                r.rd = 5'd31;
                r.cf = CF_CALL;
            end
            6'd4, 6'd5, 6'd6, 6'd7: begin
                r.rs1 = rs;
                r.rs2 = rt;
                r.op = (opc == 6'd4) ? OP_BEQ : (opc == 6'd5) ? OP_BNE :
                       (opc == 6'd6) ? OP_BLEZ : OP_BGTZ;
                r.cf = CF_BRANCH;
            end
            6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15: begin
                r.rs1 = rs;
                r.rd  = rt;
                r.use_imm = 1'b1;
                r.imm_signed = (opc < 6'd12);  // andi/ori/xori/lui zero-extend
                case (opc)
                    6'd8:  r.op = OP_ADD;
                    6'd9:  r.op = OP_ADDU;
                    6'd10: r.op = OP_SLT;
                    6'd11: r.op = OP_SLTU;
                    6'd12: r.op = OP_AND;
                    6'd13: r.op = OP_OR;
                    6'd14: r.op = OP_XOR;
                    default: r.op = OP_LUI;
                endcase
            end
            6'd16: begin
                if (rs == 5'd0) begin
                    r.op = OP_MFC0;
                    r.rd = rt;
                end else if (rs == 5'd4) begin
                    r.op = OP_MTC0;
                    r.rs1 = rt;
                end else if (rs == 5'd16 && fn == 6'd24) begin
                    r.op = OP_ERET;
                end
            end
            6'd32, 6'd33, 6'd35, 6'd36, 6'd37: begin
                r.rs1 = rs;
                r.rd  = rt;
                r.is_load = 1'b1;
                r.op = (opc == 6'd32) ? OP_LB : (opc == 6'd33) ? OP_LH :
                       (opc == 6'd35) ? OP_LW : (opc == 6'd36) ? OP_LBU : OP_LHU;
            end
            6'd40, 6'd41, 6'd43: begin
                r.rs1 = rs;
                r.rs2 = rt;
                r.is_store = 1'b1;
                r.op = (opc == 6'd40) ? OP_SB : (opc == 6'd41) ? OP_SH : OP_SW;
            end
            default: r.op = OP_INVALID;
        endcase
        r.is_controlflow = (r.cf != CF_NONE);
        r.jump_i = pc4 + off * 4;  // word offset from the delay slot
        r.jump_j = (pc4 & 32'hf000_0000) | (virt_t'(iw[25:0]) << 2);
        return r;
    endfunction

    function automatic bit opcode_kept(input logic [5:0] opc);
        return opc inside {[6'd0:6'd16], 6'd32, 6'd33, 6'd35, 6'd36, 6'd37,
                           6'd40, 6'd41, 6'd43};
    endfunction

    function automatic virt_t rand_vaddr();
        virt_t v;
        v = $urandom();
        return {v[31:2], 2'b00};
    endfunction

    function automatic inst_t make_word(input logic [5:0] opc, input logic [5:0] fn);
        return {opc, 5'($urandom()), 5'($urandom()), 5'($urandom()), 5'($urandom()), fn};
    endfunction

    task automatic check_resp(input string name, input decode_resp_t exp,
                              input decode_resp_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // present one word and hold it until accepted
    task automatic send(input virt_t va, input inst_t iw);
        int t;
        bit done;
        t = 0;
        done = 1'b0;
        while (rand_valid && $urandom_range(1, 0) == 1 && t < 4) begin
            in_valid <= 1'b0;
            @(posedge clk);
            t++;
        end
        in_valid <= 1'b1;
        in_vaddr <= va;
        in_inst  <= iw;
        t = 0;
        while (!done && t < 100) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            t++;
        end
        in_valid <= 1'b0;
        sent++;
        if (!done) begin
            errors++;
            $display("timeout: word %h at %h was never accepted", iw, va);
        end
    endtask

    task automatic finish_test(input int errs_before);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d responses missing in %s", exp_q.size(), cur_test);
            exp_q.delete();
        end
        tests++;
        $display("test %s: %0d words, %0d errors", cur_test, sent, errors - errs_before);
        @(posedge clk);
    endtask

    // scoreboard side, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && in_valid && in_ready)
            exp_q.push_back(ref_decode(in_vaddr, in_inst));
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected response in %s: %h", cur_test, out_resp);
            end else begin
                check_resp(cur_test, exp_q.pop_front(), out_resp);
            end
        end
    end

    always @(posedge clk)
        out_ready <= rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;

    initial begin
        int e0;
        logic [5:0] opc;
        void'($urandom(32'he0d66387));
        rst = 1'b1;
        in_valid = 1'b0;
        in_vaddr = '0;
        in_inst = '0;
        out_ready = 1'b0;
        rand_valid = 1'b0;
        rand_ready = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        cur_test = "special";
        sent = 0;
        e0 = errors;
        for (int f = 0; f < 64; f++)
            send(rand_vaddr(), make_word(6'd0, 6'(f)));
        finish_test(e0);

        cur_test = "immediate";
        sent = 0;
        e0 = errors;
        for (int i = 0; i < 32; i++)
            send(rand_vaddr(), make_word(6'(8 + i % 8), 6'($urandom())));
        finish_test(e0);

        cur_test = "load_store";
        sent = 0;
        e0 = errors;
        for (int i = 0; i < 27; i++) begin
            case (i % 9)
                0: opc = 6'd32;
                1: opc = 6'd33;
                2: opc = 6'd35;
                3: opc = 6'd36;
                4: opc = 6'd37;
                5: opc = 6'd40;
                6: opc = 6'd41;
                7: opc = 6'd43;
                default: opc = 6'd39;  // unused load slot
            endcase
            send(rand_vaddr(), make_word(opc, 6'($urandom())));
        end
        finish_test(e0);

        cur_test = "control_flow";
        sent = 0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            for (int b = 2; b < 8; b++)
                send(rand_vaddr(), make_word(6'(b), 6'($urandom())));
            send(rand_vaddr(), {6'd1, 5'($urandom()), 5'd0, 16'($urandom())});
            send(rand_vaddr(), {6'd1, 5'($urandom()), 5'd1, 16'($urandom())});
            send(rand_vaddr(), {6'd1, 5'($urandom()), 5'd16, 16'($urandom())});
            send(rand_vaddr(), {6'd1, 5'($urandom()), 5'd17, 16'($urandom())});
            send(rand_vaddr(), {6'd0, 5'd31, 15'd0, 6'd8});
            send(rand_vaddr(), make_word(6'd0, 6'd8));
            send(rand_vaddr(), make_word(6'd0, 6'd9));
        end
        finish_test(e0);

        cur_test = "cop0_unused";
        sent = 0;
        e0 = errors;
        send(rand_vaddr(), {6'd16, 5'd0, 5'($urandom()), 5'($urandom()), 11'd0});
        send(rand_vaddr(), {6'd16, 5'd4, 5'($urandom()), 5'($urandom()), 11'd0});
        send(rand_vaddr(), {6'd16, 5'd16, 15'd0, 6'd24});
        send(rand_vaddr(), {6'd16, 5'd16, 15'd0, 6'd25});
        send(rand_vaddr(), make_word(6'd16, 6'($urandom())));
        for (int i = 0; i < 16; i++) begin
            opc = 6'($urandom());
            for (int k = 0; k < 64 && opcode_kept(opc); k++)
                opc = 6'($urandom());
            send(rand_vaddr(), make_word(opc, 6'($urandom())));
        end
        finish_test(e0);

        cur_test = "random_stream";
        sent = 0;
        e0 = errors;
        rand_valid = 1'b1;
        rand_ready = 1'b1;
        for (int i = 0; i < 200; i++)
            send(rand_vaddr(), $urandom());
        rand_ready = 1'b0;
        finish_test(e0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
